//--- common/dma_pkg.sv
////////////////////////////////////////////////////////////
// Tile DMA shared definitions
// Sizes, flit encoding and configuration register map
////////////////////////////////////////////////////////////

`default_nettype none

package dma_pkg;

  // Bus and table sizes
  localparam int DATA_W        = 32;
  localparam int TABLE_ENTRIES = 4;
  localparam int POS_W         = 2;
  localparam int LEN_W         = 5;   // 1 to 16 words
  localparam int TILE_W        = 8;

  ////////////////////////////////////////////////////////////
  // NoC flit
  ////////////////////////////////////////////////////////////

  localparam int FLIT_TYPE_W = 2;
  localparam int FLIT_W      = FLIT_TYPE_W + DATA_W;  // Type field on top of body

  localparam logic [FLIT_TYPE_W-1:0] FLIT_HEADER  = 2'd1;
  localparam logic [FLIT_TYPE_W-1:0] FLIT_PAYLOAD = 2'd2;
  localparam logic [FLIT_TYPE_W-1:0] FLIT_LAST    = 2'd3;  // Final payload flit

  // Flit body, header or payload depending on the type field
  typedef union packed {
    struct packed {
      logic [TILE_W-1:0] dest_tile;
      logic [7:0]        words;
      logic [15:0]       raddr;      // Remote word address
    } hdr;
    logic [DATA_W-1:0] data;
  } dma_flit_body_u;

  ////////////////////////////////////////////////////////////
  // Register map, offset in address bits 3:2
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] REG_LADDR = 2'd0;
  localparam logic [1:0] REG_RADDR = 2'd1;
  localparam logic [1:0] REG_LEN   = 2'd2;  // Length 4:0, tile 15:8
  localparam logic [1:0] REG_CTRL  = 2'd3;  // Wr start, rd valid/done

endpackage

`default_nettype wire

//--- common/dma_wb_if.sv
////////////////////////////////////////////////////////////
// Word-wide Wishbone bundle for the memory side
////////////////////////////////////////////////////////////

`default_nettype none

interface dma_wb_if;

  logic [dma_pkg::DATA_W-1:0] adr;
  logic [dma_pkg::DATA_W-1:0] dat_w;
  logic [dma_pkg::DATA_W-1:0] dat_r;
  logic                       we;
  logic                       cyc;
  logic                       stb;
  logic                       ack;

  // Master holds its request until ack
  modport master (output adr, dat_w, we, cyc, stb, input dat_r, ack);
  modport slave  (input adr, dat_w, we, cyc, stb, output dat_r, ack);

endinterface

`default_nettype wire

//--- rtl/dma_cfg_wb.sv
////////////////////////////////////////////////////////////
// Configuration Wishbone slave
// Decodes register accesses into table writes and reads
////////////////////////////////////////////////////////////

`default_nettype none

module dma_cfg_wb (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [dma_pkg::DATA_W-1:0] cfg_adr_i,
  input  logic [dma_pkg::DATA_W-1:0] cfg_dat_i,
  input  logic                      cfg_we_i,
  input  logic                      cfg_cyc_i,
  input  logic                      cfg_stb_i,
  output logic [dma_pkg::DATA_W-1:0] cfg_dat_o,
  output logic                      cfg_ack_o,
  output logic                      tbl_wr_en_o,
  output logic [1:0]                tbl_wr_reg_o,
  output logic [dma_pkg::POS_W-1:0] tbl_wr_pos_o,
  output logic [dma_pkg::DATA_W-1:0] tbl_wr_data_o,
  output logic                      tbl_start_o,
  input  logic [dma_pkg::DATA_W-1:0] tbl_rd_data_i
);
  import dma_pkg::*;

  logic wr_cycle;
  logic is_ctrl;

  // Single cycle ack, one cycle after the request shows up
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ack_o <= 1'b0;
    end else begin
      cfg_ack_o <= cfg_cyc_i & cfg_stb_i & ~cfg_ack_o;
    end
  end

  // Address decode, also used as the read select
  assign tbl_wr_pos_o  = cfg_adr_i[5:4];   // Entry index
  assign tbl_wr_reg_o  = cfg_adr_i[3:2];   // Register offset
  assign tbl_wr_data_o = cfg_dat_i;

  assign is_ctrl  = (tbl_wr_reg_o == REG_CTRL);
  assign wr_cycle = cfg_ack_o & cfg_we_i;

  // Field writes and start pulse happen in the ack cycle
  assign tbl_wr_en_o = wr_cycle & ~is_ctrl;
  assign tbl_start_o = wr_cycle & is_ctrl & cfg_dat_i[0];

  assign cfg_dat_o = tbl_rd_data_i;

  // Decode in the ack cycle needs the request still on the bus
  a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
    cfg_ack_o |-> cfg_cyc_i && cfg_stb_i);

endmodule

`default_nettype wire

//--- rtl/dma_request_table.sv
////////////////////////////////////////////////////////////
// Transfer entry table with valid, done and irq bits
////////////////////////////////////////////////////////////

`default_nettype none

module dma_request_table (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              tbl_wr_en_i,
  input  logic [1:0]                        tbl_wr_reg_i,
  input  logic [dma_pkg::POS_W-1:0]         tbl_wr_pos_i,
  input  logic [dma_pkg::DATA_W-1:0]        tbl_wr_data_i,
  input  logic                              tbl_start_i,
  input  logic [dma_pkg::POS_W-1:0]         rd_pos_i,
  input  logic [1:0]                        rd_reg_i,
  output logic [dma_pkg::DATA_W-1:0]        tbl_rd_data_o,
  output logic [dma_pkg::TABLE_ENTRIES-1:0] valid_o,
  input  logic [dma_pkg::POS_W-1:0]         ctrl_pos_i,
  output logic [dma_pkg::DATA_W-1:0]        ctrl_laddr_o,
  output logic [dma_pkg::DATA_W-1:0]        ctrl_raddr_o,
  output logic [dma_pkg::LEN_W-1:0]         ctrl_len_o,
  output logic [dma_pkg::TILE_W-1:0]        ctrl_tile_o,
  input  logic                              done_en_i,
  input  logic [dma_pkg::POS_W-1:0]         done_pos_i,
  output logic [dma_pkg::TABLE_ENTRIES-1:0] irq_o
);
  import dma_pkg::*;

  logic [DATA_W-1:0]        laddr_q [TABLE_ENTRIES];
  logic [DATA_W-1:0]        raddr_q [TABLE_ENTRIES];
  logic [LEN_W-1:0]         len_q   [TABLE_ENTRIES];
  logic [TILE_W-1:0]        tile_q  [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] valid_q;
  logic [TABLE_ENTRIES-1:0] done_q;

  // Entry fields
  always_ff @(posedge clk) begin
    if (tbl_wr_en_i) begin
      case (tbl_wr_reg_i)
        REG_LADDR: laddr_q[tbl_wr_pos_i] <= tbl_wr_data_i;
        REG_RADDR: raddr_q[tbl_wr_pos_i] <= tbl_wr_data_i;
        REG_LEN: begin
          len_q[tbl_wr_pos_i]  <= tbl_wr_data_i[LEN_W-1:0];
          tile_q[tbl_wr_pos_i] <= tbl_wr_data_i[8 +: TILE_W];
        end
        default: ;
      endcase
    end
  end

  // Start wins over a completion of the same entry
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (done_en_i) begin
        valid_q[done_pos_i] <= 1'b0;
        done_q[done_pos_i]  <= 1'b1;
      end
      if (tbl_start_i) begin
        valid_q[tbl_wr_pos_i] <= 1'b1;
        done_q[tbl_wr_pos_i]  <= 1'b0;
      end
    end
  end

  always_comb begin
    case (rd_reg_i)
      REG_LADDR: tbl_rd_data_o = laddr_q[rd_pos_i];
      REG_RADDR: tbl_rd_data_o = raddr_q[rd_pos_i];
      REG_LEN:   tbl_rd_data_o = {{(DATA_W-16){1'b0}}, tile_q[rd_pos_i],
                                  {(8-LEN_W){1'b0}}, len_q[rd_pos_i]};
      default:   tbl_rd_data_o = {{(DATA_W-2){1'b0}}, done_q[rd_pos_i], valid_q[rd_pos_i]};
    endcase
  end

  assign ctrl_laddr_o = laddr_q[ctrl_pos_i];
  assign ctrl_raddr_o = raddr_q[ctrl_pos_i];
  assign ctrl_len_o   = len_q[ctrl_pos_i];
  assign ctrl_tile_o  = tile_q[ctrl_pos_i];

  assign valid_o = valid_q;
  assign irq_o   = done_q;

  // Initiator only completes entries that were started
  a_done_valid : assert property (@(posedge clk) disable iff (rst)
    done_en_i |-> valid_q[done_pos_i]);

endmodule

`default_nettype wire

//--- dma_initiator/dma_initiator.sv
////////////////////////////////////////////////////////////
// DMA initiator
// Reads a started entry from memory, sends it as a packet
////////////////////////////////////////////////////////////

`default_nettype none

module dma_initiator (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [dma_pkg::TABLE_ENTRIES-1:0] valid_i,
  output logic [dma_pkg::POS_W-1:0]         ctrl_pos_o,
  input  logic [dma_pkg::DATA_W-1:0]        ctrl_laddr_i,
  input  logic [dma_pkg::DATA_W-1:0]        ctrl_raddr_i,
  input  logic [dma_pkg::LEN_W-1:0]         ctrl_len_i,
  input  logic [dma_pkg::TILE_W-1:0]        ctrl_tile_i,
  output logic                              done_en_o,
  output logic [dma_pkg::POS_W-1:0]         done_pos_o,
  output logic [dma_pkg::FLIT_W-1:0]        noc_out_flit_o,
  output logic                              noc_out_valid_o,
  input  logic                              noc_out_ready_i,
  dma_wb_if.master                          mem
);
  import dma_pkg::*;

  logic                   busy_q;
  logic [POS_W-1:0]       pos_q;
  logic [POS_W-1:0]       pick;
  logic [LEN_W-1:0]       idx_q;       // Next word to read
  logic                   cyc_q;
  logic [DATA_W-1:0]      adr_q;
  logic [FLIT_W-1:0]      flit_q;      // One-flit holding register
  logic                   out_valid_q;
  logic                   flit_sent;
  logic                   last_sent;
  logic                   last_word;
  dma_flit_body_u         hdr_body;

  // Lowest valid entry
  always_comb begin
    pick = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid_i[i]) pick = POS_W'(i);
    end
  end

  assign ctrl_pos_o = busy_q ? pos_q : pick;

  always_comb begin
    hdr_body.hdr.dest_tile = ctrl_tile_i;
    hdr_body.hdr.words     = 8'(ctrl_len_i);
    hdr_body.hdr.raddr     = ctrl_raddr_i[15:0];
  end

  assign flit_sent = out_valid_q & noc_out_ready_i;
  assign last_sent = flit_sent & (flit_q[FLIT_W-1 -: FLIT_TYPE_W] == FLIT_LAST);
  assign last_word = (idx_q == ctrl_len_i - LEN_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      cyc_q       <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (!busy_q && |valid_i) begin
        busy_q      <= 1'b1;
        out_valid_q <= 1'b1;           // Header first
      end else if (flit_sent) begin
        out_valid_q <= 1'b0;
        if (last_sent) busy_q <= 1'b0;
        else           cyc_q  <= 1'b1; // Fetch next word
      end else if (cyc_q && mem.ack) begin
        cyc_q       <= 1'b0;
        out_valid_q <= 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (!busy_q && |valid_i) begin
      pos_q  <= pick;
      idx_q  <= '0;
      flit_q <= {FLIT_HEADER, hdr_body};
    end else if (flit_sent && !last_sent) begin
      adr_q <= ctrl_laddr_i + DATA_W'(idx_q);
    end else if (cyc_q && mem.ack) begin
      flit_q <= {last_word ? FLIT_LAST : FLIT_PAYLOAD, mem.dat_r};
      idx_q  <= idx_q + LEN_W'(1);
    end
  end

  assign noc_out_flit_o  = flit_q;
  assign noc_out_valid_o = out_valid_q;

  assign done_en_o  = last_sent;
  assign done_pos_o = pos_q;

  // Read-only master
  assign mem.adr   = adr_q;
  assign mem.dat_w = '0;
  assign mem.we    = 1'b0;
  assign mem.cyc   = cyc_q;
  assign mem.stb   = cyc_q;

  a_flit_hold : assert property (@(posedge clk) disable iff (rst)
    noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

`default_nettype wire

//--- dma_target/dma_target.sv
////////////////////////////////////////////////////////////
// DMA target
// Writes the payload of incoming packets to local memory
////////////////////////////////////////////////////////////

`default_nettype none

module dma_target #(
  parameter logic [dma_pkg::TILE_W-1:0] TILE_ID = '0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [dma_pkg::FLIT_W-1:0] noc_in_flit_i,
  input  logic                       noc_in_valid_i,
  output logic                       noc_in_ready_o,
  dma_wb_if.master                   mem
);
  import dma_pkg::*;

  logic                   rdy_q;
  logic                   cyc_q;
  logic                   drop_q;    // Packet for another tile
  logic [15:0]            base_q;
  logic [LEN_W-1:0]       idx_q;
  logic [DATA_W-1:0]      adr_q;
  logic [DATA_W-1:0]      dat_q;
  logic                   take;
  logic                   is_hdr;
  logic [FLIT_TYPE_W-1:0] ftype;
  dma_flit_body_u         body;

  assign ftype  = noc_in_flit_i[FLIT_W-1 -: FLIT_TYPE_W];
  assign body   = noc_in_flit_i[DATA_W-1:0];
  assign is_hdr = (ftype == FLIT_HEADER);
  assign take   = noc_in_valid_i & rdy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q  <= 1'b0;
      cyc_q  <= 1'b0;
      drop_q <= 1'b0;
    end else begin
      if (cyc_q && mem.ack) begin
        cyc_q <= 1'b0;
        rdy_q <= 1'b1;
      end else if (!cyc_q) begin
        rdy_q <= 1'b1;
      end
      if (take) begin
        if (is_hdr) begin
          drop_q <= (body.hdr.dest_tile != TILE_ID);
        end else if (!drop_q) begin
          cyc_q <= 1'b1;               // One write in flight
          rdy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (is_hdr) begin
        base_q <= body.hdr.raddr;
        idx_q  <= '0;
      end else begin
        adr_q <= DATA_W'(base_q) + DATA_W'(idx_q);
        dat_q <= body.data;
        idx_q <= idx_q + LEN_W'(1);
      end
    end
  end

  assign noc_in_ready_o = rdy_q;

  assign mem.adr   = adr_q;
  assign mem.dat_w = dat_q;
  assign mem.we    = 1'b1;
  assign mem.cyc   = cyc_q;
  assign mem.stb   = cyc_q;

endmodule

`default_nettype wire

//--- rtl/dma_wb_arbiter.sv
////////////////////////////////////////////////////////////
// Memory bus arbiter, target has priority over initiator
////////////////////////////////////////////////////////////

`default_nettype none

module dma_wb_arbiter (
  input  logic     clk,
  input  logic     rst,
  dma_wb_if.slave  init,
  dma_wb_if.slave  tgt,
  dma_wb_if.master mem
);

  logic grant_tgt_q;
  logic grant_tgt_d;
  logic owner_busy;

  assign owner_busy = grant_tgt_q ? tgt.cyc : init.cyc;

  // Hold while the owner runs a cycle, else re-arbitrate
  always_comb begin
    if (owner_busy)    grant_tgt_d = grant_tgt_q;
    else if (tgt.cyc)  grant_tgt_d = 1'b1;
    else if (init.cyc) grant_tgt_d = 1'b0;
    else               grant_tgt_d = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) grant_tgt_q <= 1'b1;
    else     grant_tgt_q <= grant_tgt_d;
  end

  assign mem.adr   = grant_tgt_q ? tgt.adr   : init.adr;
  assign mem.dat_w = grant_tgt_q ? tgt.dat_w : init.dat_w;
  assign mem.we    = grant_tgt_q ? tgt.we    : init.we;
  assign mem.cyc   = grant_tgt_q ? tgt.cyc   : init.cyc;
  assign mem.stb   = grant_tgt_q ? tgt.stb   : init.stb;

  assign init.dat_r = mem.dat_r;
  assign tgt.dat_r  = mem.dat_r;
  assign init.ack   = mem.ack & ~grant_tgt_q;
  assign tgt.ack    = mem.ack & grant_tgt_q;

  // An ack only reaches the side that owns the running cycle
  a_ack_owner : assert property (@(posedge clk) disable iff (rst)
    mem.ack |-> (grant_tgt_q ? tgt.cyc : init.cyc));

endmodule

`default_nettype wire

//--- rtl/dma_top.sv
////////////////////////////////////////////////////////////
// Tile DMA engine top level
// Config slave, NoC in/out and shared memory master
////////////////////////////////////////////////////////////

`default_nettype none

module dma_top #(
  parameter logic [dma_pkg::TILE_W-1:0] TILE_ID = '0
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [dma_pkg::DATA_W-1:0]        cfg_adr_i,
  input  logic [dma_pkg::DATA_W-1:0]        cfg_dat_i,
  input  logic                              cfg_we_i,
  input  logic                              cfg_cyc_i,
  input  logic                              cfg_stb_i,
  output logic [dma_pkg::DATA_W-1:0]        cfg_dat_o,
  output logic                              cfg_ack_o,
  output logic [dma_pkg::FLIT_W-1:0]        noc_out_flit_o,
  output logic                              noc_out_valid_o,
  input  logic                              noc_out_ready_i,
  input  logic [dma_pkg::FLIT_W-1:0]        noc_in_flit_i,
  input  logic                              noc_in_valid_i,
  output logic                              noc_in_ready_o,
  output logic [dma_pkg::DATA_W-1:0]        mem_adr_o,
  output logic [dma_pkg::DATA_W-1:0]        mem_dat_o,
  output logic                              mem_we_o,
  output logic                              mem_cyc_o,
  output logic                              mem_stb_o,
  input  logic [dma_pkg::DATA_W-1:0]        mem_dat_i,
  input  logic                              mem_ack_i,
  output logic [dma_pkg::TABLE_ENTRIES-1:0] irq_o
);
  import dma_pkg::*;

  logic                     tbl_wr_en;
  logic [1:0]               tbl_wr_reg;
  logic [POS_W-1:0]         tbl_wr_pos;
  logic [DATA_W-1:0]        tbl_wr_data;
  logic                     tbl_start;
  logic [DATA_W-1:0]        tbl_rd_data;
  logic [TABLE_ENTRIES-1:0] valid;
  logic [POS_W-1:0]         ctrl_pos;
  logic [DATA_W-1:0]        ctrl_laddr;
  logic [DATA_W-1:0]        ctrl_raddr;
  logic [LEN_W-1:0]         ctrl_len;
  logic [TILE_W-1:0]        ctrl_tile;
  logic                     done_en;
  logic [POS_W-1:0]         done_pos;

  dma_wb_if init_bus ();
  dma_wb_if tgt_bus ();
  dma_wb_if mem_bus ();

  dma_cfg_wb cfg_i (
    .clk, .rst,
    .cfg_adr_i, .cfg_dat_i, .cfg_we_i, .cfg_cyc_i, .cfg_stb_i,
    .cfg_dat_o, .cfg_ack_o,
    .tbl_wr_en_o   (tbl_wr_en),
    .tbl_wr_reg_o  (tbl_wr_reg),
    .tbl_wr_pos_o  (tbl_wr_pos),
    .tbl_wr_data_o (tbl_wr_data),
    .tbl_start_o   (tbl_start),
    .tbl_rd_data_i (tbl_rd_data)
  );

  // Read select is the decoded config address
  dma_request_table table_i (
    .clk, .rst,
    .tbl_wr_en_i   (tbl_wr_en),
    .tbl_wr_reg_i  (tbl_wr_reg),
    .tbl_wr_pos_i  (tbl_wr_pos),
    .tbl_wr_data_i (tbl_wr_data),
    .tbl_start_i   (tbl_start),
    .rd_pos_i      (tbl_wr_pos),
    .rd_reg_i      (tbl_wr_reg),
    .tbl_rd_data_o (tbl_rd_data),
    .valid_o       (valid),
    .ctrl_pos_i    (ctrl_pos),
    .ctrl_laddr_o  (ctrl_laddr),
    .ctrl_raddr_o  (ctrl_raddr),
    .ctrl_len_o    (ctrl_len),
    .ctrl_tile_o   (ctrl_tile),
    .done_en_i     (done_en),
    .done_pos_i    (done_pos),
    .irq_o
  );

  dma_initiator init_i (
    .clk, .rst,
    .valid_i      (valid),
    .ctrl_pos_o   (ctrl_pos),
    .ctrl_laddr_i (ctrl_laddr),
    .ctrl_raddr_i (ctrl_raddr),
    .ctrl_len_i   (ctrl_len),
    .ctrl_tile_i  (ctrl_tile),
    .done_en_o    (done_en),
    .done_pos_o   (done_pos),
    .noc_out_flit_o, .noc_out_valid_o, .noc_out_ready_i,
    .mem          (init_bus)
  );

  dma_target #(.TILE_ID(TILE_ID)) tgt_i (
    .clk, .rst,
    .noc_in_flit_i, .noc_in_valid_i, .noc_in_ready_o,
    .mem (tgt_bus)
  );

  dma_wb_arbiter arb_i (
    .clk, .rst,
    .init (init_bus),
    .tgt  (tgt_bus),
    .mem  (mem_bus)
  );

  // Flatten the arbitrated bus
  assign mem_adr_o     = mem_bus.adr;
  assign mem_dat_o     = mem_bus.dat_w;
  assign mem_we_o      = mem_bus.we;
  assign mem_cyc_o     = mem_bus.cyc;
  assign mem_stb_o     = mem_bus.stb;
  assign mem_bus.dat_r = mem_dat_i;
  assign mem_bus.ack   = mem_ack_i;

endmodule

`default_nettype wire

//--- testbench/dma_tb_mem.sv
////////////////////////////////////////////////////////////
// Wishbone memory model for the DMA testbench
// Random contents, 0 to 3 wait cycles per access
////////////////////////////////////////////////////////////

`default_nettype none

module dma_tb_mem #(
  parameter int WORDS = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic        we_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  logic [31:0] mem [WORDS];
  integer      seed = 32'h4472;
  int          wait_cnt;     // Wait cycles left before the next ack

  initial begin
    for (int a = 0; a < WORDS; a++) begin
      mem[a] = $random(seed);
    end
    wait_cnt = $unsigned($random(seed)) % 4;
    ack_o    = 1'b0;
    dat_o    = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      ack_o <= 1'b0;
    end else if (ack_o) begin
      ack_o <= 1'b0;                       // Master drops cyc on this edge
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == 0) begin
        ack_o    <= 1'b1;
        wait_cnt <= $unsigned($random(seed)) % 4;
        if (we_i) mem[adr_i[9:0]] <= dat_i;
        else      dat_o <= mem[adr_i[9:0]];
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/dma_tb.sv
////////////////////////////////////////////////////////////
// Tile DMA testbench
// Config, NoC traffic and memory checked against a model
////////////////////////////////////////////////////////////

`default_nettype none

module dma_tb #(
  parameter int                          TIMEOUT = 2000,
  parameter logic [dma_pkg::TILE_W-1:0]  MY_TILE = 8'd5
);
  import dma_pkg::*;

  logic                     clk;
  logic                     rst;
  logic [DATA_W-1:0]        cfg_adr;
  logic [DATA_W-1:0]        cfg_wdata;
  logic                     cfg_we;
  logic                     cfg_cyc;
  logic                     cfg_stb;
  logic [DATA_W-1:0]        cfg_rdata;
  logic                     cfg_ack;
  logic [FLIT_W-1:0]        out_flit;
  logic                     out_valid;
  logic                     out_ready;
  logic [FLIT_W-1:0]        in_flit;
  logic                     in_valid;
  logic                     in_ready;
  logic [DATA_W-1:0]        mem_adr;
  logic [DATA_W-1:0]        mem_wdata;
  logic                     mem_we;
  logic                     mem_cyc;
  logic                     mem_stb;
  logic [DATA_W-1:0]        mem_rdata;
  logic                     mem_ack;
  logic [TABLE_ENTRIES-1:0] irq;

  // Reference model
  integer            seed       = 32'h4472;
  integer            stall_seed = 32'h4472;
  logic              hold_out;                // Forces noc_out ready low
  logic [31:0]       shadow [1024];
  logic [31:0]       m_laddr [TABLE_ENTRIES];
  logic [31:0]       m_raddr [TABLE_ENTRIES];
  logic [LEN_W-1:0]  m_len   [TABLE_ENTRIES];
  logic [TILE_W-1:0] m_tile  [TABLE_ENTRIES];
  logic [FLIT_W-1:0] out_q [$];               // Flits seen on noc_out
  logic [FLIT_W-1:0] in_q [$];                // Flits waiting for noc_in
  int                gap_q [$];

  initial clk = 1'b0;
  always #5 clk = ~clk;

  dma_top #(.TILE_ID(MY_TILE)) dut_i (
    .clk, .rst,
    .cfg_adr_i (cfg_adr), .cfg_dat_i (cfg_wdata), .cfg_we_i (cfg_we),
    .cfg_cyc_i (cfg_cyc), .cfg_stb_i (cfg_stb),
    .cfg_dat_o (cfg_rdata), .cfg_ack_o (cfg_ack),
    .noc_out_flit_o (out_flit), .noc_out_valid_o (out_valid), .noc_out_ready_i (out_ready),
    .noc_in_flit_i (in_flit), .noc_in_valid_i (in_valid), .noc_in_ready_o (in_ready),
    .mem_adr_o (mem_adr), .mem_dat_o (mem_wdata), .mem_we_o (mem_we),
    .mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb),
    .mem_dat_i (mem_rdata), .mem_ack_i (mem_ack),
    .irq_o (irq)
  );

  dma_tb_mem mem_i (
    .clk, .rst,
    .adr_i (mem_adr), .dat_i (mem_wdata), .we_i (mem_we),
    .cyc_i (mem_cyc), .stb_i (mem_stb),
    .dat_o (mem_rdata), .ack_o (mem_ack)
  );

  // NoC out sink, a flit moves on valid and ready
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) out_q.push_back(out_flit);
  end

  always @(negedge clk) begin
    out_ready = !hold_out && ($unsigned($random(stall_seed)) % 4 != 0);
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] reg_addr(input int e, input logic [1:0] r);
    return {26'd0, 2'(e), r, 2'b00};
  endfunction

  task automatic end_in_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic timeout_failure(input string what);
    $display("Timeout at time %0t while waiting for %s", $time, what);
    end_in_failure();
  endtask

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time %0t %s: got %0h, expected %0h",
               $time, name, actual, expected);
      end_in_failure();
    end
  endtask

  // One config access, called and returning on a falling edge
  task automatic cfg_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cnt;
    cfg_adr   = adr;
    cfg_wdata = wdata;
    cfg_we    = we;
    cfg_cyc   = 1'b1;
    cfg_stb   = 1'b1;
    cnt       = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) timeout_failure("the config ack");
    end while (!cfg_ack);
    rdata = cfg_rdata;
    @(negedge clk);                        // Write lands on the ack edge
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we  = 1'b0;
  endtask

  task automatic cfg_write(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] rd_ignored;
    cfg_access(1'b1, adr, data, rd_ignored);
  endtask

  task automatic cfg_read(input logic [31:0] adr, output logic [31:0] data);
    cfg_access(1'b0, adr, 32'd0, data);
  endtask

  task automatic program_entry(input int e);
    logic [31:0] junk;
    m_laddr[e] = rand_below(512 - 16);     // Reads stay in the lower half
    m_raddr[e] = $random(seed);
    m_len[e]   = 1 + rand_below(16);
    m_tile[e]  = rand_below(256);
    junk       = $random(seed);
    cfg_write(reg_addr(e, REG_LADDR), m_laddr[e]);
    cfg_write(reg_addr(e, REG_RADDR), m_raddr[e]);
    cfg_write(reg_addr(e, REG_LEN), {junk[31:16], m_tile[e], junk[7:5], m_len[e]});
  endtask

  task automatic readback_entry(input int e);
    logic [31:0] rd;
    cfg_read(reg_addr(e, REG_LADDR), rd);
    check_equal("cfg LADDR", rd, m_laddr[e]);
    cfg_read(reg_addr(e, REG_RADDR), rd);
    check_equal("cfg RADDR", rd, m_raddr[e]);
    cfg_read(reg_addr(e, REG_LEN), rd);
    check_equal("cfg LEN", rd, {16'd0, m_tile[e], 3'd0, m_len[e]});
  endtask

  task automatic start_entry(input int e);
    cfg_write(reg_addr(e, REG_CTRL), 32'h1);
    check_equal("irq after start", irq[e], 1'b0);
  endtask

  task automatic pop_out_flit(output logic [FLIT_W-1:0] f);
    int cnt;
    cnt = 0;
    while (out_q.size() == 0) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) timeout_failure("an outgoing flit");
    end
    f = out_q.pop_front();
  endtask

  task automatic expect_packet(input int e);
    logic [FLIT_W-1:0] f;
    dma_flit_body_u    b;
    int                i;
    pop_out_flit(f);
    b = f[DATA_W-1:0];
    check_equal("header type", f[FLIT_W-1 -: FLIT_TYPE_W], FLIT_HEADER);
    check_equal("header dest_tile", b.hdr.dest_tile, m_tile[e]);
    check_equal("header words", b.hdr.words, m_len[e]);
    check_equal("header raddr", b.hdr.raddr, m_raddr[e][15:0]);
    for (i = 0; i < m_len[e]; i++) begin
      pop_out_flit(f);
      check_equal("payload type", f[FLIT_W-1 -: FLIT_TYPE_W],
                  (i == m_len[e] - 1) ? FLIT_LAST : FLIT_PAYLOAD);
      check_equal("payload data", f[DATA_W-1:0], shadow[m_laddr[e] + i]);
    end
  endtask

  // Completion shows up on irq and in CTRL
  task automatic finish_entry(input int e);
    logic [31:0] rd;
    int          cnt;
    cnt = 0;
    while (!irq[e]) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) timeout_failure("an entry irq bit");
    end
    cfg_read(reg_addr(e, REG_CTRL), rd);
    check_equal("CTRL after done", rd, 32'h2);
  endtask

  task automatic queue_in_packet(input logic [TILE_W-1:0] tile, input int n);
    dma_flit_body_u b;
    logic [31:0]    raddr;
    logic [31:0]    data;
    int             i;
    raddr           = 512 + rand_below(512 - 16);   // Writes stay in the upper half
    b.hdr.dest_tile = tile;
    b.hdr.words     = 8'(n);
    b.hdr.raddr     = raddr[15:0];
    in_q.push_back({FLIT_HEADER, b});
    gap_q.push_back(rand_below(3));
    for (i = 0; i < n; i++) begin
      data = $random(seed);
      in_q.push_back({(i == n - 1) ? FLIT_LAST : FLIT_PAYLOAD, data});
      gap_q.push_back(rand_below(3));
      if (tile == MY_TILE) shadow[raddr + i] = data;
    end
  endtask

  task automatic drive_in_flits();
    int cnt;
    int gap;
    while (in_q.size() > 0) begin
      gap = gap_q.pop_front();
      repeat (gap) @(negedge clk);
      in_flit  = in_q.pop_front();
      in_valid = 1'b1;
      cnt      = 0;
      while (!in_ready) begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) timeout_failure("noc_in ready");
      end
      @(negedge clk);                      // Flit taken on the edge before
      in_valid = 1'b0;
    end
    cnt = 0;
    while (!in_ready) begin                // Last memory write still pending
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) timeout_failure("the last incoming write");
    end
  endtask

  task automatic compare_memory();
    int a;
    for (a = 0; a < 1024; a++) begin
      check_equal($sformatf("mem[%0d]", a), mem_i.mem[a], shadow[a]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          i;
    int          j;
    int          e;
    int          tmp;
    int          order [TABLE_ENTRIES];
    logic [7:0]  other;
    logic [31:0] rd;
    rst       = 1'b1;
    cfg_adr   = '0;
    cfg_wdata = '0;
    cfg_we    = 1'b0;
    cfg_cyc   = 1'b0;
    cfg_stb   = 1'b0;
    out_ready = 1'b0;
    hold_out  = 1'b0;
    in_flit   = '0;
    in_valid  = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < 1024; i++) shadow[i] = mem_i.mem[i];

    // Register readback
    for (e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_read(reg_addr(e, REG_CTRL), rd);
      check_equal("CTRL after reset", rd, 32'h0);
    end
    for (j = 0; j < 2; j++) begin
      for (e = 0; e < TABLE_ENTRIES; e++) program_entry(e);
      tmp = rand_below(TABLE_ENTRIES);
      for (i = 0; i < TABLE_ENTRIES; i++) readback_entry((tmp + i) % TABLE_ENTRIES);
    end

    // Single outgoing transfers under ready stalls
    for (i = 0; i < 8; i++) begin
      e = rand_below(TABLE_ENTRIES);
      program_entry(e);
      start_entry(e);
      expect_packet(e);
      finish_entry(e);
    end

    // Incoming packets, every other one for a foreign tile
    other = rand_below(256);
    if (other == MY_TILE) other = other + 8'd1;
    for (i = 0; i < 4; i++) queue_in_packet((i % 2 == 0) ? MY_TILE : other, 1 + rand_below(16));
    drive_in_flits();
    compare_memory();

    // Both directions at once
    for (e = 0; e < TABLE_ENTRIES; e++) begin
      program_entry(e);
      order[e] = e;
    end
    for (i = TABLE_ENTRIES - 1; i > 0; i--) begin
      j        = rand_below(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < 3; i++) queue_in_packet((i == 1) ? other : MY_TILE, 1 + rand_below(16));
    hold_out = 1'b1;                       // First packet waits until all are started
    fork
      begin
        for (i = 0; i < TABLE_ENTRIES; i++) start_entry(order[i]);
        hold_out = 1'b0;
        expect_packet(order[0]);
        for (e = 0; e < TABLE_ENTRIES; e++) begin
          if (e != order[0]) expect_packet(e);   // Lowest valid entry goes next
        end
      end
      drive_in_flits();
    join
    for (e = 0; e < TABLE_ENTRIES; e++) finish_entry(e);
    compare_memory();
    check_equal("extra outgoing flits", out_q.size(), 0);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/dma_pkg.sv
common/dma_wb_if.sv
rtl/dma_cfg_wb.sv
rtl/dma_request_table.sv
dma_initiator/dma_initiator.sv
dma_target/dma_target.sv
rtl/dma_wb_arbiter.sv
rtl/dma_top.sv
testbench/dma_tb_mem.sv
testbench/dma_tb.sv

//--- Bender.yml
package:
  name: tile_dma

sources:
  - common/dma_pkg.sv
  - common/dma_wb_if.sv
  - rtl/dma_cfg_wb.sv
  - rtl/dma_request_table.sv
  - dma_initiator/dma_initiator.sv
  - dma_target/dma_target.sv
  - rtl/dma_wb_arbiter.sv
  - rtl/dma_top.sv
  - target: test
    files:
      - testbench/dma_tb_mem.sv
      - testbench/dma_tb.sv
